// File: logic/cpu_pipelined.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_pipelined import cpu_pkg::*; #(
   parameter int MEM_DEPTH = 256
) (
   input  wire        clk,
   input  wire        rst,
   input  wire        run,
   input  wire        prog_valid,
   input  wire word_t prog_addr,
   input  wire word_t prog_data,
   output logic       prog_ready,
   output logic       wb_valid,
   output reg_idx_t   wb_reg,
   output word_t      wb_data,
   output logic       store_valid,
   output word_t      store_addr,
   output word_t      store_data,
   output logic       halted
);

   word_t    fetch_addr;
   word_t    fetch_data;
   word_t    issue_instr;
   logic     stall;
   logic     jump_taken;
   word_t    jump_target;
   reg_idx_t read_reg_0;
   reg_idx_t read_reg_1;
   word_t    reg_data_0;
   word_t    reg_data_1;
   word_t    mem_instr;
   word_t    mem_result;
   reg_idx_t write_reg;
   word_t    write_data;
   logic     write_en;
   logic     halt_done;

   pipe_stage_if dec_to_exe ();
   pipe_stage_if exe_to_mem ();

   stage_fetch #(
      .MEM_DEPTH(MEM_DEPTH)
   ) u_stage_fetch (
      .clk(clk),
      .rst(rst),
      .run(run),
      .fetch_data(fetch_data),
      .stall(stall),
      .jump_taken(jump_taken),
      .jump_target(jump_target),
      .halt_done(halt_done),
      .fetch_addr(fetch_addr),
      .issue_instr(issue_instr),
      .prog_ready(prog_ready)
   );

   stall_detector u_stall_detector (
      .issue_instr(issue_instr),
      .decode_instr(dec_to_exe.instr),
      .execute_instr(exe_to_mem.instr),
      .memory_instr(mem_instr),
      .stall(stall)
   );

   register_file u_register_file (
      .clk(clk),
      .rst(rst),
      .read_reg_0(read_reg_0),
      .read_reg_1(read_reg_1),
      .write_reg(write_reg),
      .write_data(write_data),
      .write_en(write_en),
      .read_data_0(reg_data_0),
      .read_data_1(reg_data_1)
   );

   stage_decode u_stage_decode (
      .clk(clk),
      .rst(rst),
      .issue_instr(issue_instr),
      .stall(stall),
      .reg_data_0(reg_data_0),
      .reg_data_1(reg_data_1),
      .read_reg_0(read_reg_0),
      .read_reg_1(read_reg_1),
      .jump_taken(jump_taken),
      .jump_target(jump_target),
      .dec_out(dec_to_exe.producer)
   );

   stage_execute u_stage_execute (
      .clk(clk),
      .rst(rst),
      .exe_in(dec_to_exe.consumer),
      .exe_out(exe_to_mem.producer)
   );

   stage_memory #(
      .MEM_DEPTH(MEM_DEPTH)
   ) u_stage_memory (
      .clk(clk),
      .rst(rst),
      .prog_valid(prog_valid),
      .prog_ready(prog_ready),
      .prog_addr(prog_addr),
      .prog_data(prog_data),
      .fetch_addr(fetch_addr),
      .mem_in(exe_to_mem.consumer),
      .fetch_data(fetch_data),
      .mem_instr(mem_instr),
      .mem_result(mem_result),
      .store_valid(store_valid),
      .store_addr(store_addr),
      .store_data(store_data)
   );

   stage_write_back u_stage_write_back (
      .mem_instr(mem_instr),
      .mem_result(mem_result),
      .write_reg(write_reg),
      .write_data(write_data),
      .write_en(write_en),
      .wb_valid(wb_valid),
      .wb_reg(wb_reg),
      .wb_data(wb_data),
      .halt_done(halt_done)
   );

   // Sticky until reset
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         halted <= 1'b0;
      end else begin
         halted <= halted | halt_done;
      end
   end

endmodule

`default_nettype wire

// File: logic/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_idx_t;
   typedef logic [4:0]  opcode_t;
   typedef logic [4:0]  alu_op_t;

   // Instruction types, bits 31:27
   localparam opcode_t OP_NOP      = 5'd0;
   localparam opcode_t OP_LOAD_IMM = 5'd1;
   localparam opcode_t OP_LOAD_MEM = 5'd2;
   localparam opcode_t OP_STORE    = 5'd3;
   localparam opcode_t OP_ALU      = 5'd4;
   localparam opcode_t OP_JUMP     = 5'd5;
   localparam opcode_t OP_HALT     = 5'd6;

   localparam alu_op_t ALU_ADD = 5'd0;
   localparam alu_op_t ALU_SUB = 5'd1;
   localparam alu_op_t ALU_AND = 5'd2;
   localparam alu_op_t ALU_OR  = 5'd3;
   localparam alu_op_t ALU_XOR = 5'd4;
   localparam alu_op_t ALU_SHL = 5'd5;
   localparam alu_op_t ALU_SHR = 5'd6;
   localparam alu_op_t ALU_SLT = 5'd7;

   // Bubble in the pipeline
   localparam word_t NOP_WORD = {OP_NOP, 27'b0};

   typedef enum logic [1:0] {LOADING, RUNNING, HALTING, HALTED} fetch_state_e;

   function automatic opcode_t get_opcode(word_t instr);
      return instr[31:27];
   endfunction

   function automatic reg_idx_t get_rd(word_t instr);
      return instr[26:22];
   endfunction

   function automatic reg_idx_t get_ra(word_t instr);
      return instr[21:17];
   endfunction

   function automatic reg_idx_t get_rb(word_t instr);
      return instr[16:12];
   endfunction

   function automatic word_t get_imm(word_t instr);
      return {16'b0, instr[15:0]};
   endfunction

   function automatic alu_op_t get_alu_op(word_t instr);
      return instr[4:0];
   endfunction

   function automatic logic writes_reg(word_t instr);
      return get_opcode(instr) inside {OP_LOAD_IMM, OP_LOAD_MEM, OP_ALU};
   endfunction

   function automatic logic reads_ra(word_t instr);
      return get_opcode(instr) inside {OP_LOAD_MEM, OP_STORE, OP_ALU, OP_JUMP};
   endfunction

   function automatic logic reads_rb(word_t instr);
      return get_opcode(instr) inside {OP_STORE, OP_ALU, OP_JUMP};
   endfunction

endpackage

`default_nettype wire

// File: logic/pipe_stage_if.sv
`timescale 1ns/1ps
`default_nettype none

interface pipe_stage_if import cpu_pkg::*; ();

   // One instruction with its operands, NOP acts as a bubble
   word_t instr;
   word_t a_value;
   word_t b_value;
   word_t result;

   modport producer (
      output instr,
      output a_value,
      output b_value,
      output result
   );

   modport consumer (
      input instr,
      input a_value,
      input b_value,
      input result
   );

endinterface

`default_nettype wire

// File: logic/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file import cpu_pkg::*; (
   input  wire           clk,
   input  wire           rst,
   input  wire reg_idx_t read_reg_0,
   input  wire reg_idx_t read_reg_1,
   input  wire reg_idx_t write_reg,
   input  wire word_t    write_data,
   input  wire           write_en,
   output word_t         read_data_0,
   output word_t         read_data_1
);

   word_t regs [32];

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (write_en) begin
         regs[write_reg] <= write_data;
      end
   end

   // Write first, so a same-cycle read sees the new value
   assign read_data_0 = (write_en && write_reg == read_reg_0) ? write_data : regs[read_reg_0];
   assign read_data_1 = (write_en && write_reg == read_reg_1) ? write_data : regs[read_reg_1];

endmodule

`default_nettype wire

// File: logic/stage_decode.sv
`timescale 1ns/1ps
`default_nettype none

module stage_decode import cpu_pkg::*; (
   input  wire            clk,
   input  wire            rst,
   input  wire word_t     issue_instr,
   input  wire            stall,
   input  wire word_t     reg_data_0,
   input  wire word_t     reg_data_1,
   output reg_idx_t       read_reg_0,
   output reg_idx_t       read_reg_1,
   output logic           jump_taken,
   output word_t          jump_target,
   pipe_stage_if.producer dec_out
);

   logic is_jump;

   // ra on port 0, rb on port 1 for every type
   assign read_reg_0 = get_ra(issue_instr);
   assign read_reg_1 = get_rb(issue_instr);

   // Jump resolves here from the register values
   assign is_jump     = (get_opcode(issue_instr) == OP_JUMP);
   assign jump_taken  = is_jump && !stall && (reg_data_0 != '0);
   assign jump_target = reg_data_1;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         dec_out.instr <= NOP_WORD;
      end else begin
         dec_out.instr <= stall ? NOP_WORD : issue_instr;
      end
   end

   // Unused operands go down as zero
   always_ff @(posedge clk) begin
      dec_out.a_value <= reads_ra(issue_instr) ? reg_data_0 : '0;
      dec_out.b_value <= reads_rb(issue_instr) ? reg_data_1 : '0;
   end

   assign dec_out.result = '0;

endmodule

`default_nettype wire

// File: logic/stage_execute.sv
`timescale 1ns/1ps
`default_nettype none

module stage_execute import cpu_pkg::*; (
   input  wire            clk,
   input  wire            rst,
   pipe_stage_if.consumer exe_in,
   pipe_stage_if.producer exe_out
);

   word_t alu_result;
   word_t result;

   always_comb begin
      case (get_alu_op(exe_in.instr))
         ALU_ADD: alu_result = exe_in.a_value + exe_in.b_value;
         ALU_SUB: alu_result = exe_in.a_value - exe_in.b_value;
         ALU_AND: alu_result = exe_in.a_value & exe_in.b_value;
         ALU_OR:  alu_result = exe_in.a_value | exe_in.b_value;
         ALU_XOR: alu_result = exe_in.a_value ^ exe_in.b_value;
         ALU_SHL: alu_result = exe_in.a_value << exe_in.b_value[4:0];
         ALU_SHR: alu_result = exe_in.a_value >> exe_in.b_value[4:0];
         ALU_SLT: alu_result = {31'b0, $signed(exe_in.a_value) < $signed(exe_in.b_value)};
         default: alu_result = '0;
      endcase
   end

   always_comb begin
      case (get_opcode(exe_in.instr))
         OP_ALU:      result = alu_result;
         OP_LOAD_IMM: result = get_imm(exe_in.instr);
         default:     result = exe_in.result;
      endcase
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         exe_out.instr <= NOP_WORD;
      end else begin
         exe_out.instr <= exe_in.instr;
      end
   end

   always_ff @(posedge clk) begin
      exe_out.a_value <= exe_in.a_value;
      exe_out.b_value <= exe_in.b_value;
      exe_out.result  <= result;
   end

endmodule

`default_nettype wire

// File: logic/stage_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module stage_fetch import cpu_pkg::*; #(
   parameter int MEM_DEPTH = 256
) (
   input  wire        clk,
   input  wire        rst,
   input  wire        run,
   input  wire word_t fetch_data,
   input  wire        stall,
   input  wire        jump_taken,
   input  wire word_t jump_target,
   input  wire        halt_done,
   output word_t      fetch_addr,
   output word_t      issue_instr,
   output logic       prog_ready
);

   fetch_state_e state;
   word_t        pc;
   word_t        pc_next;

   assign pc_next    = (pc == word_t'(MEM_DEPTH - 1)) ? '0 : pc + 1'b1;
   assign fetch_addr = pc;
   assign prog_ready = (state == LOADING);

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         state       <= LOADING;
         pc          <= '0;
         issue_instr <= NOP_WORD;
      end else begin
         case (state)
            LOADING: begin
               if (run) begin
                  state <= RUNNING;
                  pc    <= '0;
               end
            end
            RUNNING: begin
               // Stall holds both PC and issue register
               if (!stall) begin
                  if (jump_taken) begin
                     // Squash the word fetched behind the jump
                     pc          <= jump_target % word_t'(MEM_DEPTH);
                     issue_instr <= NOP_WORD;
                  end else if (get_opcode(issue_instr) == OP_HALT) begin
                     state       <= HALTING;
                     issue_instr <= NOP_WORD;
                  end else begin
                     pc          <= pc_next;
                     issue_instr <= fetch_data;
                  end
               end
            end
            HALTING: begin
               if (halt_done) begin
                  state <= HALTED;
               end
            end
            default: begin
               state <= HALTED;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: logic/stage_memory.sv
`timescale 1ns/1ps
`default_nettype none

module stage_memory import cpu_pkg::*; #(
   parameter int MEM_DEPTH = 256
) (
   input  wire            clk,
   input  wire            rst,
   input  wire            prog_valid,
   input  wire            prog_ready,
   input  wire word_t     prog_addr,
   input  wire word_t     prog_data,
   input  wire word_t     fetch_addr,
   pipe_stage_if.consumer mem_in,
   output word_t          fetch_data,
   output word_t          mem_instr,
   output word_t          mem_result,
   output logic           store_valid,
   output word_t          store_addr,
   output word_t          store_data
);

   localparam int ADDR_W = $clog2(MEM_DEPTH);

   typedef logic [ADDR_W-1:0] mem_idx_t;

   word_t mem [MEM_DEPTH];

   // Addresses wrap at the memory depth
   function automatic mem_idx_t to_index(word_t addr);
      return mem_idx_t'(addr % word_t'(MEM_DEPTH));
   endfunction

   assign fetch_data = mem[to_index(fetch_addr)];

   // STORE writes ra's value to the address in rb
   assign store_valid = (get_opcode(mem_in.instr) == OP_STORE);
   assign store_addr  = mem_in.b_value;
   assign store_data  = mem_in.a_value;

   // Program load and stores never overlap
   always_ff @(posedge clk) begin
      if (prog_valid && prog_ready) begin
         mem[to_index(prog_addr)] <= prog_data;
      end else if (store_valid) begin
         mem[to_index(store_addr)] <= store_data;
      end
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         mem_instr <= NOP_WORD;
      end else begin
         mem_instr <= mem_in.instr;
      end
   end

   always_ff @(posedge clk) begin
      if (get_opcode(mem_in.instr) == OP_LOAD_MEM) begin
         mem_result <= mem[to_index(mem_in.a_value)];
      end else begin
         mem_result <= mem_in.result;
      end
   end

endmodule

`default_nettype wire

// File: logic/stage_write_back.sv
`timescale 1ns/1ps
`default_nettype none

module stage_write_back import cpu_pkg::*; (
   input  wire word_t mem_instr,
   input  wire word_t mem_result,
   output reg_idx_t   write_reg,
   output word_t      write_data,
   output logic       write_en,
   output logic       wb_valid,
   output reg_idx_t   wb_reg,
   output word_t      wb_data,
   output logic       halt_done
);

   // Register file write
   assign write_en   = writes_reg(mem_instr);
   assign write_reg  = get_rd(mem_instr);
   assign write_data = mem_result;

   // Observation pulse mirrors the write
   assign wb_valid = write_en;
   assign wb_reg   = write_reg;
   assign wb_data  = write_data;

   assign halt_done = (get_opcode(mem_instr) == OP_HALT);

endmodule

`default_nettype wire

// File: logic/stall_detector.sv
`timescale 1ns/1ps
`default_nettype none

module stall_detector import cpu_pkg::*; (
   input  wire word_t issue_instr,
   input  wire word_t decode_instr,
   input  wire word_t execute_instr,
   input  wire word_t memory_instr,
   output logic       stall
);

   // RAW check of one consumer against one in-flight producer
   function automatic logic depends_on(word_t consumer, word_t producer);
      reg_idx_t dest;
      logic     hit_a;
      logic     hit_b;
      dest  = get_rd(producer);
      hit_a = reads_ra(consumer) && (get_ra(consumer) == dest);
      hit_b = reads_rb(consumer) && (get_rb(consumer) == dest);
      return writes_reg(producer) && (hit_a || hit_b);
   endfunction

   logic hit_decode;
   logic hit_execute;
   logic hit_memory;

   assign hit_decode  = depends_on(issue_instr, decode_instr);
   assign hit_execute = depends_on(issue_instr, execute_instr);
   assign hit_memory  = depends_on(issue_instr, memory_instr);

   assign stall = hit_decode || hit_execute || hit_memory;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary -Wno-fatal --top-module tb_cpu_pipelined -f tb.f -o tb_cpu_pipelined &&
./obj_dir/tb_cpu_pipelined || exit 1

// File: sim/cpu_stimulus.txt
# Tag then hex fields. T starts a test, E ends it. P addr word loads a program word,
# W reg data is an expected register write, S addr data an expected store, in program order.
T load immediates
P 00000000 08401234
P 00000001 0880FFFF
P 00000002 0FC08001
P 00000003 09400000
P 00000004 30000000
W 01 00001234
W 02 0000FFFF
W 1F 00008001
W 05 00000000
E
T eight ALU codes, each right after its producer
P 00000000 084000F0
P 00000001 08800003
P 00000002 20C22000
P 00000003 21043001
P 00000004 21481002
P 00000005 218A2003
P 00000006 21CC1004
P 00000007 220E2005
P 00000008 22502006
P 00000009 22889007
P 0000000A 22C8A006
P 0000000B 23164007
P 0000000C 30000000
W 01 000000F0
W 02 00000003
W 03 000000F3
W 04 FFFFFF10
W 05 00000010
W 06 00000013
W 07 000000E3
W 08 00000718
W 09 000000E3
W 0A 00000001
W 0B 7FFFFF88
W 0C 00000000
E
T store then load back
P 00000000 0840BEEF
P 00000001 08800080
P 00000002 18022000
P 00000003 10C40000
P 00000004 09000081
P 00000005 18084000
P 00000006 11480000
P 00000007 30000000
W 01 0000BEEF
W 02 00000080
S 00000080 0000BEEF
W 03 0000BEEF
W 04 00000081
S 00000081 00000081
W 05 00000081
E
T taken and not-taken jumps
P 00000000 08400001
P 00000001 08800006
P 00000002 28022000
P 00000003 08C0DEAD
P 00000004 0900DEAD
P 00000005 30000000
P 00000006 09400055
P 00000007 09800000
P 00000008 280C2000
P 00000009 09C00077
P 0000000A 30000000
W 01 00000001
W 02 00000006
W 05 00000055
W 06 00000000
W 07 00000077
E
T countdown loop loaded out of order
P 00000007 09400090
P 00000002 08C00004
P 00000009 30000000
P 00000000 08400003
P 00000005 20422001
P 00000003 09000000
P 00000008 18085000
P 00000001 08800001
P 00000006 28023000
P 00000004 21081000
W 01 00000003
W 02 00000001
W 03 00000004
W 04 00000000
W 04 00000003
W 01 00000002
W 04 00000005
W 01 00000001
W 04 00000006
W 01 00000000
W 05 00000090
S 00000090 00000006
E

// File: sim/tb_cpu_pipelined.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_pipelined import cpu_pkg::*; ();

   localparam int CLK_PERIOD    = 4;
   localparam int RESET_CYCLES  = 5;
   localparam int SETTLE_CYCLES = 10;

   logic     clk;
   logic     rst;
   logic     run;
   logic     prog_valid;
   word_t    prog_addr;
   word_t    prog_data;
   logic     prog_ready;
   logic     wb_valid;
   reg_idx_t wb_reg;
   word_t    wb_data;
   logic     store_valid;
   word_t    store_addr;
   word_t    store_data;
   logic     halted;

   // Program, expected trace and observed trace of the current test
   word_t prog_addr_q[$];
   word_t prog_data_q[$];
   word_t exp_wb_reg_q[$];
   word_t exp_wb_data_q[$];
   word_t exp_st_addr_q[$];
   word_t exp_st_data_q[$];
   word_t got_wb_reg_q[$];
   word_t got_wb_data_q[$];
   word_t got_st_addr_q[$];
   word_t got_st_data_q[$];

   int test_num         = 0;
   int cycle_count      = 0;
   int test_start_cycle = 0;
   int watchdog_limit   = 1000;

   cpu_pipelined #(
      .MEM_DEPTH(256)
   ) u_cpu_pipelined (
      .clk(clk),
      .rst(rst),
      .run(run),
      .prog_valid(prog_valid),
      .prog_addr(prog_addr),
      .prog_data(prog_data),
      .prog_ready(prog_ready),
      .wb_valid(wb_valid),
      .wb_reg(wb_reg),
      .wb_data(wb_data),
      .store_valid(store_valid),
      .store_addr(store_addr),
      .store_data(store_data),
      .halted(halted)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic check_value(input string what, input word_t actual, input word_t expected);
      if (actual !== expected) begin
         $display("MISMATCH at time %0t: %s, got %h, expected %h", $time, what, actual, expected);
         $display("Some tests failed");
         $fatal(1, "value check failed");
      end
   endtask

   task automatic abort_run(input string reason);
      $display("ERROR: %s", reason);
      $display("Some tests failed");
      $fatal(1, "run aborted");
   endtask

   task automatic apply_reset;
      @(posedge clk);
      rst        <= 1'b0;
      run        <= 1'b0;
      prog_valid <= 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b1;
      @(negedge clk);
      check_value("prog_ready after reset", word_t'(prog_ready), 32'd1);
      check_value("wb_valid after reset", word_t'(wb_valid), 32'd0);
      check_value("store_valid after reset", word_t'(store_valid), 32'd0);
      check_value("halted after reset", word_t'(halted), 32'd0);
   endtask

   task automatic load_program;
      int gap;
      for (int i = 0; i < prog_addr_q.size(); i++) begin
         gap = $urandom % 4;
         repeat (gap) begin
            @(posedge clk);
            prog_valid <= 1'b0;
         end
         @(posedge clk);
         prog_valid <= 1'b1;
         prog_addr  <= prog_addr_q[i];
         prog_data  <= prog_data_q[i];
         // Word is taken on the next rising edge with ready high
         @(negedge clk);
         while (!prog_ready) @(negedge clk);
      end
      @(posedge clk);
      prog_valid <= 1'b0;
   endtask

   task automatic start_run;
      @(posedge clk);
      run <= 1'b1;
      @(posedge clk);
      run <= 1'b0;
   endtask

   task automatic sample_outputs;
      if (wb_valid) begin
         got_wb_reg_q.push_back(word_t'(wb_reg));
         got_wb_data_q.push_back(wb_data);
      end
      if (store_valid) begin
         got_st_addr_q.push_back(store_addr);
         got_st_data_q.push_back(store_data);
      end
      check_value("prog_ready after run", word_t'(prog_ready), 32'd0);
   endtask

   task automatic collect_outputs;
      while (!halted) begin
         @(negedge clk);
         sample_outputs();
      end
      // Nothing more may come out once halted
      repeat (SETTLE_CYCLES) begin
         @(negedge clk);
         sample_outputs();
         check_value("halted stays high", word_t'(halted), 32'd1);
      end
   endtask

   task automatic compare_traces;
      if (got_wb_data_q.size() != exp_wb_data_q.size()) begin
         abort_run($sformatf("test %0d saw %0d register writes but expected %0d",
                             test_num, got_wb_data_q.size(), exp_wb_data_q.size()));
      end
      if (got_st_data_q.size() != exp_st_data_q.size()) begin
         abort_run($sformatf("test %0d saw %0d stores but expected %0d",
                             test_num, got_st_data_q.size(), exp_st_data_q.size()));
      end
      for (int i = 0; i < exp_wb_data_q.size(); i++) begin
         check_value($sformatf("test %0d write %0d register", test_num, i),
                     got_wb_reg_q[i], exp_wb_reg_q[i]);
         check_value($sformatf("test %0d write %0d data", test_num, i),
                     got_wb_data_q[i], exp_wb_data_q[i]);
      end
      for (int i = 0; i < exp_st_data_q.size(); i++) begin
         check_value($sformatf("test %0d store %0d address", test_num, i),
                     got_st_addr_q[i], exp_st_addr_q[i]);
         check_value($sformatf("test %0d store %0d data", test_num, i),
                     got_st_data_q[i], exp_st_data_q[i]);
      end
   endtask

   task automatic clear_queues;
      prog_addr_q.delete();
      prog_data_q.delete();
      exp_wb_reg_q.delete();
      exp_wb_data_q.delete();
      exp_st_addr_q.delete();
      exp_st_data_q.delete();
      got_wb_reg_q.delete();
      got_wb_data_q.delete();
      got_st_addr_q.delete();
      got_st_data_q.delete();
   endtask

   task automatic run_test;
      test_start_cycle = cycle_count;
      watchdog_limit   = 200 * prog_addr_q.size() + 1000;
      apply_reset();
      load_program();
      start_run();
      collect_outputs();
      compare_traces();
      $display("Test %0d done: %0d writes, %0d stores", test_num,
               got_wb_data_q.size(), got_st_data_q.size());
   endtask

   initial begin : main
      int    fd;
      int    n;
      string line;
      byte   tag;
      word_t field_a;
      word_t field_b;
      rst        <= 1'b0;
      run        <= 1'b0;
      prog_valid <= 1'b0;
      prog_addr  <= '0;
      prog_data  <= '0;
      void'($urandom(32'hc42a700c));
      fd = $fopen("sim/cpu_stimulus.txt", "r");
      if (fd == 0) begin
         abort_run("cannot open sim/cpu_stimulus.txt");
      end
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (line.len() == 0) begin
            tag = "#";
         end else begin
            tag = line.getc(0);
         end
         case (tag)
            "T": begin
               test_num++;
               clear_queues();
            end
            "P", "W", "S": begin
               n = $sscanf(line.substr(1, line.len() - 1), "%h %h", field_a, field_b);
               if (n != 2) begin
                  abort_run($sformatf("malformed stimulus line in test %0d", test_num));
               end
               if (tag == "P") begin
                  prog_addr_q.push_back(field_a);
                  prog_data_q.push_back(field_b);
               end else if (tag == "W") begin
                  exp_wb_reg_q.push_back(field_a);
                  exp_wb_data_q.push_back(field_b);
               end else begin
                  exp_st_addr_q.push_back(field_a);
                  exp_st_data_q.push_back(field_b);
               end
            end
            "E": run_test();
            default: begin
            end
         endcase
      end
      $fclose(fd);
      if (test_num == 0) begin
         abort_run("the stimulus file holds no tests");
      end else begin
         $display("All tests passed");
         $finish;
      end
   end

   // Limit restarts with each test
   initial begin : watchdog
      while ((cycle_count - test_start_cycle) <= watchdog_limit) begin
         @(posedge clk);
         cycle_count++;
      end
      abort_run($sformatf("watchdog expired after %0d cycles in test %0d, the DUT never halted",
                          watchdog_limit, test_num));
   end

endmodule

`default_nettype wire

// File: tb.f
logic/cpu_pkg.sv
logic/pipe_stage_if.sv
logic/stage_fetch.sv
logic/stall_detector.sv
logic/register_file.sv
logic/stage_decode.sv
logic/stage_execute.sv
logic/stage_memory.sv
logic/stage_write_back.sv
logic/cpu_pipelined.sv
sim/tb_cpu_pipelined.sv
